//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= scroll_layer_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

SRCS := $(shell cat $(FLIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || (echo "simulation ended without a verdict"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/scroll_layer_chk.sv
// fetcher protocol assertions, bound into every tile_line_fetch instance; quiet during reset
`timescale 1ns/1ps

module scroll_layer_chk (
    input logic clk,
    input logic rst,
    input logic start,
    input logic done,
    input logic vram_cs,
    input logic rom_cs,
    input logic buf_wr
);

    // vram and rom are never selected in the same cycle
    cs_exclusive: assert property (@(posedge clk) disable iff (rst) !(vram_cs && rom_cs))
        else $error("vram_cs and rom_cs high in the same cycle");

    no_write_when_done: assert property (@(posedge clk) disable iff (rst) done |-> !buf_wr)
        else $error("buf_wr high while done is high");

    // done is only released by a low start
    done_held: assert property (@(posedge clk) disable iff (rst) $fell(done) |-> !$past(start))
        else $error("done fell while start was still high");

endmodule

//--- dv/scroll_layer_tb.sv
// directed testbench for scroll_layer at tile_size 8; vram and rom are behavioural models
`timescale 1ns/1ps

module scroll_layer_tb;

    localparam int line_w = tile_pkg::line_w;

    logic                         clk = 1'b0;
    logic                         rst;
    logic                         reg_we, frame_start, start, line_start;
    logic [1:0]                   reg_sel;
    logic [15:0]                  reg_wdata;
    logic [8:0]                   v;
    logic                         done, vram_cs, rom_cs;
    logic                         vram_ok = 1'b0;
    logic                         rom_ok = 1'b0;
    logic [tile_pkg::vram_aw-1:0] vram_addr, vram_last;
    logic [tile_pkg::rom_aw-1:0]  rom_addr, rom_last;
    logic [15:0]                  vram_data = '0;
    logic [15:0]                  rom_data = '0;
    logic [tile_pkg::buf_aw-1:0]  pix_addr;
    logic [tile_pkg::pix_w-1:0]   pix_data;

    logic [tile_pkg::pix_w-1:0]   exp_line [line_w];
    logic [15:0]                  sh_base, sh_hpos, sh_vpos;     // expected shadow copies
    logic [15:0]                  act_base, act_hpos, act_vpos;  // expected active copies
    int                           mism_cnt, fail_cnt, vram_wait, rom_wait;
    bit                           stall_on, vram_pend, rom_pend;

    scroll_layer #(.tile_size(8)) dut_i (.*);

    bind tile_line_fetch scroll_layer_chk chk_i (
        .clk(clk), .rst(rst), .start(start), .done(done),
        .vram_cs(vram_cs), .rom_cs(rom_cs), .buf_wr(buf_wr)
    );

    always #50 clk = ~clk;

    function automatic logic [15:0] vram_word(input logic [tile_pkg::vram_aw-1:0] a);
        if (a[0]) return a[15:0] ^ 16'h00a5;         // attribute
        else return a[15:0] * 16'd3 + 16'd5;         // code
    endfunction

    function automatic logic [15:0] rom_word(input logic [tile_pkg::rom_aw-1:0] a);
        return a[15:0] * 16'h9e37;
    endfunction

    // ok comes after 0..3 cycles; a taken word or a new address starts a fresh delay
    always @(posedge clk) begin
        #1;
        if (!vram_cs) begin
            vram_pend = 1'b0;
            vram_ok   = 1'b0;
        end else begin
            if (!vram_pend || vram_ok || vram_addr != vram_last) begin
                vram_pend = 1'b1;
                vram_last = vram_addr;
                vram_wait = stall_on ? int'($urandom_range(3, 0)) : 0;
            end else if (vram_wait > 0) begin
                vram_wait = vram_wait - 1;
            end
            vram_ok   = (vram_wait == 0);
            vram_data = vram_word(vram_addr);
        end
    end

    always @(posedge clk) begin
        #1;
        if (!rom_cs) begin
            rom_pend = 1'b0;
            rom_ok   = 1'b0;
        end else begin
            if (!rom_pend || rom_ok || rom_addr != rom_last) begin
                rom_pend = 1'b1;
                rom_last = rom_addr;
                rom_wait = stall_on ? int'($urandom_range(3, 0)) : 0;
            end else if (rom_wait > 0) begin
                rom_wait = rom_wait - 1;
            end
            rom_ok   = (rom_wait == 0);
            rom_data = rom_word(rom_addr);
        end
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_pix(input string name, input logic [tile_pkg::pix_w-1:0] got, exp);
        if (got !== exp) begin
            mism_cnt++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_reg(input string name, input logic [15:0] got, exp);
        if (got !== exp) begin
            mism_cnt++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_active();
        check_reg("vram_base", dut_i.vram_base, act_base);
        check_reg("hpos", dut_i.hpos, act_hpos);
        check_reg("vpos", dut_i.vpos, act_vpos);
    endtask

    // expected line from the map, rom and bit-plane rules, whole tiles until 383 is covered
    task automatic compute_ref(input logic [8:0] line_v);
        logic [8:0]  vn, hn, a;
        logic [11:0] scan;
        logic [23:0] ca;
        logic [15:0] code, attr, w, sh;
        int          cnt, fine;
        vn   = act_vpos[8:0] + line_v;
        hn   = {act_hpos[8:3], 3'd0};
        fine = int'(act_hpos[2:0]);
        cnt  = 0;
        while (cnt < line_w + fine) begin
            scan = {vn[8], hn[8:3], vn[7:3]};
            ca   = 24'(act_base) * 24'd256 + 24'(scan) * 24'd2;
            code = vram_word(ca);
            attr = vram_word(ca + 24'd1);
            w    = rom_word({3'd1, 1'b0, code, vn[2:0]});   // both words share one address
            for (int wd = 0; wd < 2; wd++) begin
                for (int k = 0; k < 4; k++) begin
                    sh = w >> k;
                    a  = 9'(cnt - fine);
                    if (a < 9'(line_w)) exp_line[a] = {attr[3:0], sh[12], sh[8], sh[4], sh[0]};
                    cnt++;
                end
                hn = hn + 9'd4;
            end
        end
    endtask

    task automatic wait_done(input logic level, input int limit);
        int n;
        n = 0;
        while (done !== level && n < limit) begin
            step();
            n++;
        end
        if (done !== level) begin
            fail_cnt++;
            $display("timeout: done did not go to %0d within %0d cycles", level, limit);
        end
    endtask

    task automatic write_reg(input logic [1:0] sel, input logic [15:0] data, input bit frame);
        reg_we      = 1'b1;
        reg_sel     = sel;
        reg_wdata   = data;
        frame_start = frame;
        step();
        reg_we      = 1'b0;
        frame_start = 1'b0;
        case (sel)
            tile_pkg::reg_base: sh_base = data;
            tile_pkg::reg_hpos: sh_hpos = data;
            tile_pkg::reg_vpos: sh_vpos = data;
            default: ;
        endcase
        if (frame) begin
            act_base = sh_base;
            act_hpos = sh_hpos;
            act_vpos = sh_vpos;
        end
    endtask

    task automatic begin_line(input logic [8:0] line_v);
        v     = line_v;
        start = 1'b1;
    endtask

    task automatic end_line();
        wait_done(1'b1, 4000);
        start = 1'b0;
        step();
        wait_done(1'b0, 8);
        line_start = 1'b1;                     // filled bank becomes the read bank
        step();
        line_start = 1'b0;
    endtask

    task automatic read_line(input string tag);
        for (int i = 0; i < line_w; i++) begin
            pix_addr = 9'(i);
            step();
            check_pix($sformatf("%s pix_data[%0d]", tag, i), pix_data, exp_line[pix_addr]);
        end
    endtask

    task automatic render_check(input logic [8:0] line_v, input string tag);
        compute_ref(line_v);
        begin_line(line_v);
        end_line();
        read_line(tag);
    endtask

    task automatic test_plain();
        render_check(9'd0, "plain v0");
        render_check(9'd37, "plain v37");
    endtask

    task automatic test_shadow();
        write_reg(tile_pkg::reg_hpos, 16'h0005, 1'b0);
        write_reg(tile_pkg::reg_vpos, 16'h0028, 1'b0);
        write_reg(tile_pkg::reg_base, 16'h0012, 1'b0);
        check_active();                        // still the reset values
        render_check(9'd10, "shadow held");
        write_reg(tile_pkg::reg_hpos, 16'h0002, 1'b1);   // write and frame_start together
        check_active();
        render_check(9'd10, "shadow applied");
    endtask

    task automatic test_fine();
        write_reg(tile_pkg::reg_base, 16'h0000, 1'b0);
        write_reg(tile_pkg::reg_vpos, 16'h0000, 1'b0);
        write_reg(tile_pkg::reg_hpos, 16'h0003, 1'b1);
        render_check(9'd64, "fine");
    endtask

    task automatic test_vscroll();
        write_reg(tile_pkg::reg_hpos, 16'h0000, 1'b0);
        write_reg(tile_pkg::reg_base, 16'h0234, 1'b0);
        write_reg(tile_pkg::reg_vpos, 16'h0095, 1'b1);
        render_check(9'd200, "vscroll");
    endtask

    task automatic test_stall();
        stall_on = 1'b1;
        write_reg(tile_pkg::reg_hpos, 16'h010d, 1'b1);
        render_check(9'd5, "stall v5");
        render_check(9'd99, "stall v99");
        render_check(9'd300, "stall v300");
        stall_on = 1'b0;
    endtask

    task automatic test_bank_swap();
        render_check(9'd20, "swap line n");
        begin_line(9'd21);
        read_line("swap during n+1");          // exp_line still holds line n
        if (done) begin
            fail_cnt++;
            $display("line n+1 finished before the read of line n, no overlap shown");
        end
        end_line();
        compute_ref(9'd21);
        read_line("swap line n+1");
    endtask

    initial begin
        void'($urandom(32'heb4f));
        rst         = 1'b1;
        reg_we      = 1'b0;
        reg_sel     = '0;
        reg_wdata   = '0;
        frame_start = 1'b0;
        v           = '0;
        start       = 1'b0;
        line_start  = 1'b0;
        pix_addr    = '0;
        stall_on    = 1'b0;
        {sh_base, sh_hpos, sh_vpos}    = '0;
        {act_base, act_hpos, act_vpos} = '0;
        mism_cnt    = 0;
        fail_cnt    = 0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        check_active();
        test_plain();
        test_shadow();
        test_fine();
        test_vscroll();
        test_stall();
        test_bank_swap();
        $display("errors: %0d mismatches, %0d other failures", mism_cnt, fail_cnt);
        if (mism_cnt + fail_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- flist.f
logic/tile_pkg.sv
logic/scroll_regs.sv
logic/tile_line_fetch.sv
logic/line_buffer.sv
logic/scroll_layer.sv
dv/scroll_layer_chk.sv
dv/scroll_layer_tb.sv

//--- logic/line_buffer.sv
// ping-pong pixel buffer; line_start swaps banks, reads see the other bank one cycle later
`timescale 1ns/1ps

module line_buffer (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        line_start,
    input  logic                        buf_wr,
    input  logic [tile_pkg::buf_aw-1:0] buf_addr,
    input  logic [tile_pkg::pix_w-1:0]  buf_data,
    input  logic [tile_pkg::buf_aw-1:0] pix_addr,
    output logic [tile_pkg::pix_w-1:0]  pix_data
);

    localparam int depth = 2 ** (tile_pkg::buf_aw + 1);   // both banks

    logic [tile_pkg::pix_w-1:0] mem [depth];
    logic                       bank;      // bank being filled

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank <= 1'b0;
        end else if (line_start) begin
            bank <= ~bank;
        end
    end

    // write side, fetcher
    always_ff @(posedge clk) begin
        if (buf_wr) begin
            mem[{bank, buf_addr}] <= buf_data;
        end
    end

    // read side, video
    always_ff @(posedge clk) begin
        pix_data <= mem[{~bank, pix_addr}];
    end

endmodule

//--- logic/scroll_layer.sv
// scroll layer top; vram and rom are external and answer each chip select with an ok level
`timescale 1ns/1ps

module scroll_layer #(
    parameter int tile_size = 8            // 8, 16 or 32
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        reg_we,
    input  logic [1:0]                  reg_sel,
    input  logic [15:0]                 reg_wdata,
    input  logic                        frame_start,
    input  logic [8:0]                  v,
    input  logic                        start,
    output logic                        done,
    output logic [tile_pkg::vram_aw-1:0] vram_addr,
    input  logic [15:0]                 vram_data,
    input  logic                        vram_ok,
    output logic                        vram_cs,
    output logic [tile_pkg::rom_aw-1:0] rom_addr,
    input  logic [15:0]                 rom_data,
    input  logic                        rom_ok,
    output logic                        rom_cs,
    input  logic                        line_start,
    input  logic [tile_pkg::buf_aw-1:0] pix_addr,
    output logic [tile_pkg::pix_w-1:0]  pix_data
);

    logic [15:0]                 vram_base, hpos, vpos;
    logic [tile_pkg::buf_aw-1:0] buf_addr;
    logic [tile_pkg::pix_w-1:0]  buf_data;
    logic                        buf_wr;

    scroll_regs regs_i (
        .clk         (clk),
        .rst         (rst),
        .reg_we      (reg_we),
        .reg_sel     (reg_sel),
        .reg_wdata   (reg_wdata),
        .frame_start (frame_start),
        .vram_base   (vram_base),
        .hpos        (hpos),
        .vpos        (vpos)
    );

    tile_line_fetch #(
        .tile_size (tile_size)
    ) fetch_i (
        .clk       (clk),
        .rst       (rst),
        .v         (v),
        .vram_base (vram_base),
        .hpos      (hpos),
        .vpos      (vpos),
        .start     (start),
        .done      (done),
        .vram_addr (vram_addr),
        .vram_data (vram_data),
        .vram_ok   (vram_ok),
        .vram_cs   (vram_cs),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .rom_cs    (rom_cs),
        .buf_addr  (buf_addr),
        .buf_data  (buf_data),
        .buf_wr    (buf_wr)
    );

    line_buffer lbuf_i (
        .clk        (clk),
        .rst        (rst),
        .line_start (line_start),
        .buf_wr     (buf_wr),
        .buf_addr   (buf_addr),
        .buf_data   (buf_data),
        .pix_addr   (pix_addr),
        .pix_data   (pix_data)
    );

endmodule

//--- logic/scroll_regs.sv
// shadow scroll registers; a host write and frame_start in one cycle copy the new value
`timescale 1ns/1ps

module scroll_regs (
    input  logic        clk,
    input  logic        rst,
    input  logic        reg_we,
    input  logic [1:0]  reg_sel,
    input  logic [15:0] reg_wdata,
    input  logic        frame_start,
    output logic [15:0] vram_base,
    output logic [15:0] hpos,
    output logic [15:0] vpos
);

    logic [15:0] base_s, hpos_s, vpos_s;   // shadow copies
    logic [15:0] base_n, hpos_n, vpos_n;   // shadow after this cycle's write

    always_comb begin
        base_n = base_s;
        hpos_n = hpos_s;
        vpos_n = vpos_s;
        if (reg_we) begin
            case (reg_sel)
                tile_pkg::reg_base: base_n = reg_wdata;
                tile_pkg::reg_hpos: hpos_n = reg_wdata;
                tile_pkg::reg_vpos: vpos_n = reg_wdata;
                default: ;                 // code 3 is unused
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            base_s    <= '0;
            hpos_s    <= '0;
            vpos_s    <= '0;
            vram_base <= '0;
            hpos      <= '0;
            vpos      <= '0;
        end else begin
            base_s <= base_n;
            hpos_s <= hpos_n;
            vpos_s <= vpos_n;
            // active set only moves at frame start, so no mid-frame tearing
            if (frame_start) begin
                vram_base <= base_n;
                hpos      <= hpos_n;
                vpos      <= vpos_n;
            end
        end
    end

endmodule

//--- logic/tile_line_fetch.sv
// renders one line per start level; only the tile_size 8 map layout is verified, no flip bits
`timescale 1ns/1ps

module tile_line_fetch #(
    parameter int tile_size = 8            // 8, 16 or 32
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [8:0]                  v,
    input  logic [15:0]                 vram_base,
    input  logic [15:0]                 hpos,
    input  logic [15:0]                 vpos,
    input  logic                        start,
    output logic                        done,
    output logic [tile_pkg::vram_aw-1:0] vram_addr,
    input  logic [15:0]                 vram_data,
    input  logic                        vram_ok,
    output logic                        vram_cs,
    output logic [tile_pkg::rom_aw-1:0] rom_addr,
    input  logic [15:0]                 rom_data,
    input  logic                        rom_ok,
    output logic                        rom_cs,
    output logic [tile_pkg::buf_aw-1:0] buf_addr,
    output logic [tile_pkg::pix_w-1:0]  buf_data,
    output logic                        buf_wr
);

    localparam logic [2:0] st_idle = 3'd0;
    localparam logic [2:0] st_scan = 3'd1;
    localparam logic [2:0] st_code = 3'd2;
    localparam logic [2:0] st_gap  = 3'd3;
    localparam logic [2:0] st_attr = 3'd4;
    localparam logic [2:0] st_roma = 3'd5;
    localparam logic [2:0] st_gfx  = 3'd6;
    localparam logic [2:0] st_pix  = 3'd7;

    // rom region prefix and the index of the last graphics word of a tile row
    localparam logic [2:0] rom_id  = (tile_size == 8)  ? 3'd1 :
                                     (tile_size == 16) ? 3'd2 : 3'd3;
    localparam logic [2:0] wd_last = 3'(tile_size / 4 - 1);

    logic [2:0]  st;
    logic [1:0]  pix_k;                    // pixel within a graphics word
    logic [2:0]  wd;                       // graphics word within a tile row
    logic [8:0]  vn;                       // scrolled line
    logic [8:0]  hn;                       // scrolled column
    logic [2:0]  fine;                     // fine horizontal scroll
    logic [9:0]  cnt;                      // pixels produced so far
    logic [15:0] code, attr;
    logic [15:0] pxl;
    logic [11:0] scan;
    logic        line_end;

    function automatic logic [3:0] colour(input logic [15:0] w);
        return {w[12], w[8], w[4], w[0]};  // planar bits, plane 3 first
    endfunction

    always_comb begin
        case (tile_size)
            16:      scan = {vn[8:7], hn[8:3], vn[6:3]};
            32:      scan = {vn[8:6], hn[8:3], vn[5:3]};
            default: scan = {vn[8], hn[8:3], vn[7:3]};
        endcase
    end

    // last written address is cnt - 1 - fine, so this means 383 is covered
    assign line_end = cnt >= 10'(tile_pkg::line_w) + {7'd0, fine};

    // control state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st      <= st_idle;
            done    <= 1'b0;
            vram_cs <= 1'b0;
            rom_cs  <= 1'b0;
            buf_wr  <= 1'b0;
            pix_k   <= '0;
            wd      <= '0;
        end else begin
            case (st)
                st_idle: begin
                    if (!start) begin
                        done <= 1'b0;      // line acknowledged
                    end else if (!done) begin
                        st <= st_scan;
                    end
                end
                st_scan: begin
                    buf_wr <= 1'b0;
                    if (line_end) begin
                        done <= 1'b1;
                        st   <= st_idle;
                    end else begin
                        vram_cs <= 1'b1;
                        st      <= st_code;
                    end
                end
                st_code: if (vram_ok) st <= st_gap;
                st_gap:  st <= st_attr;    // let vram see the attribute address
                st_attr: begin
                    if (vram_ok) begin
                        vram_cs <= 1'b0;
                        st      <= st_roma;
                    end
                end
                st_roma: begin
                    rom_cs <= 1'b1;
                    wd     <= '0;
                    st     <= st_gfx;
                end
                st_gfx: begin
                    buf_wr <= 1'b0;
                    if (rom_ok) begin
                        pix_k <= '0;
                        st    <= st_pix;
                    end
                end
                default: begin             // st_pix
                    buf_wr <= 1'b1;
                    pix_k  <= pix_k + 2'd1;
                    if (pix_k == 2'd3) begin
                        if (wd == wd_last) begin
                            rom_cs <= 1'b0;
                            st     <= st_scan;     // next tile
                        end else begin
                            wd <= wd + 3'd1;
                            st <= st_gfx;
                        end
                    end
                end
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        case (st)
            st_idle: begin
                vn   <= vpos[8:0] + v;
                hn   <= {hpos[8:3], 3'd0};
                fine <= hpos[2:0];
                cnt  <= '0;
            end
            st_scan: vram_addr <= {vram_base, 8'd0} + {11'd0, scan, 1'b0};
            st_code: begin
                if (vram_ok) begin
                    code         <= vram_data;
                    vram_addr[0] <= 1'b1;  // attribute follows the code
                end
            end
            st_attr: if (vram_ok) attr <= vram_data;
            st_roma: begin
                case (tile_size)
                    16:      rom_addr <= {rom_id, code, vn[3:0]};
                    32:      rom_addr <= {rom_id, code[13:0], vn[4:0], 1'b0};
                    default: rom_addr <= {rom_id, 1'b0, code, vn[2:0]};
                endcase
            end
            st_gfx: begin
                if (rom_ok) begin
                    pxl <= rom_data;       // four pixels
                    hn  <= hn + 9'd4;
                    if (tile_size == 32 && wd == 3'd3) rom_addr[0] <= 1'b1;
                end
            end
            st_pix: begin
                buf_addr <= cnt[8:0] - {6'd0, fine};   // wraps mod 512
                buf_data <= {attr[3:0], colour(pxl)};
                pxl      <= pxl >> 1;
                cnt      <= cnt + 10'd1;
            end
            default: ;
        endcase
    end

endmodule

//--- logic/tile_pkg.sv
// shared widths and register codes for the scroll layer; word addresses only, 16-bit data buses
package tile_pkg;

    // memory address widths, in words
    localparam int vram_aw = 24;           // vram_base * 256 + scan * 2
    localparam int rom_aw  = 23;           // 3-bit region prefix + 20-bit offset

    // line buffer geometry
    localparam int buf_aw  = 9;            // 512 entries per bank
    localparam int pix_w   = 8;            // palette in [7:4], colour index in [3:0]
    localparam int line_w  = 384;          // visible pixels per line

    // host register selects
    localparam logic [1:0] reg_base = 2'd0;    // tilemap base in vram
    localparam logic [1:0] reg_hpos = 2'd1;    // horizontal scroll
    localparam logic [1:0] reg_vpos = 2'd2;    // vertical scroll

endpackage
